/* design/instr_decoder.sv */
// Instruction decoder that picks the execution unit, operand selection, register use and legality
`default_nettype none

module instr_decoder (
    input  wire logic                       instr_valid,
    input  wire logic [isa_pkg::ILEN-1:0]   instr,
    output logic                            illegal_instruction,
    output logic                            is_legal,
    output issue_pkg::unit_t                unit,
    output issue_pkg::operand_sel_t         operand_sel,
    output logic                            uses_rs1,
    output logic                            uses_rs2,
    output logic                            writes_rd
);
    import isa_pkg::*;
    import issue_pkg::*;

    logic [OPC_W-1:0] opc_trim;
    logic [FN3_W-1:0] fn3;
    logic             mul_div_op;

    assign opc_trim   = instr[6:2];
    assign fn3        = instr[14:12];
    assign mul_div_op = instr[25];

    //////////////////////////////////////////////////
    // Opcode classification
    always_comb begin
        logic known_opc;
        logic uses_rd;
        logic legal;

        known_opc   = 1'b1;
        uses_rd     = 1'b1;
        unit        = UNIT_ALU;
        operand_sel = SEL_RS1_RS2;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b0;

        case (opcode_t'(opc_trim))
            OP_LUI: begin
                operand_sel = SEL_ZERO_UPPER;
                uses_rs1    = 1'b0;
            end
            OP_AUIPC: begin
                operand_sel = SEL_PC_UPPER;
                uses_rs1    = 1'b0;
            end
            OP_JAL: begin
                // Target comes from the PC carried alongside the operands
                unit     = UNIT_BRANCH;
                uses_rs1 = 1'b0;
            end
            OP_JALR: begin
                unit        = UNIT_BRANCH;
                operand_sel = SEL_RS1_IMM;
            end
            OP_BRANCH: begin
                unit     = UNIT_BRANCH;
                uses_rs2 = 1'b1;
                uses_rd  = 1'b0;
            end
            OP_LOAD: begin
                unit        = UNIT_LSU;
                operand_sel = SEL_ADDR_RS2;
            end
            OP_STORE: begin
                unit        = UNIT_LSU;
                operand_sel = SEL_ADDR_RS2;
                uses_rs2    = 1'b1;
                uses_rd     = 1'b0;
            end
            OP_ARITH_IMM: begin
                operand_sel = SEL_RS1_IMM;
            end
            OP_ARITH: begin
                uses_rs2 = 1'b1;
                if (mul_div_op) begin
                    unit = UNIT_MUL;
                end
            end
            default: begin
                known_opc = 1'b0;
            end
        endcase

        // Divides share the ARITH encoding with fn3[2] set and have no unit
        legal = known_opc && (instr[1:0] == LEN32_BITS) &&
                !((opcode_t'(opc_trim) == OP_ARITH) && mul_div_op && fn3[2]);

        writes_rd           = uses_rd && (instr[11:7] != '0);
        is_legal            = instr_valid && legal;
        illegal_instruction = instr_valid && !legal;
    end

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
// RV32 instruction-set types: trimmed major opcodes and instruction field widths
`default_nettype none

package isa_pkg;

    // Instruction and field widths
    parameter int ILEN  = 32;
    parameter int OPC_W = 5;
    parameter int FN3_W = 3;

    // Low two bits of every 32-bit encoding
    parameter logic [1:0] LEN32_BITS = 2'b11;

    // Major opcode with the two length bits stripped (instr[6:2])
    typedef enum logic [OPC_W-1:0] {
        OP_LOAD      = 5'b00000,
        OP_ARITH_IMM = 5'b00100,
        OP_AUIPC     = 5'b00101,
        OP_STORE     = 5'b01000,
        OP_ARITH     = 5'b01100,
        OP_LUI       = 5'b01101,
        OP_BRANCH    = 5'b11000,
        OP_JALR      = 5'b11001,
        OP_JAL       = 5'b11011
    } opcode_t;

endpackage

`default_nettype wire

/* design/issue_config.svh */
// Issue stage configuration constants shared by the design and its testbench
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Data and PC width
`define XLEN 32

// Architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// Execution units fed by the issue stage
`define NUM_UNITS 4

// Input-buffer slots per unit, and a counter wide enough to hold that count
`define UNIT_CREDITS 2
`define CREDIT_W 2

`endif

/* design/issue_pkg.sv */
// Issue-side types: execution unit selection and operand selection
`default_nettype none

package issue_pkg;

    // Execution units, also the index into per-unit credit vectors
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BRANCH = 2'd1,
        UNIT_LSU    = 2'd2,
        UNIT_MUL    = 2'd3
    } unit_t;

    // How the two unit operands are formed
    typedef enum logic [2:0] {
        SEL_RS1_RS2    = 3'd0,
        SEL_RS1_IMM    = 3'd1,
        SEL_ZERO_UPPER = 3'd2,
        SEL_PC_UPPER   = 3'd3,
        SEL_ADDR_RS2   = 3'd4
    } operand_sel_t;

endpackage

`default_nettype wire

/* design/issue_stage.sv */
// Issue stage top: decode, hazard and credit checks, and the registered issue packet
`default_nettype none

`include "issue_config.svh"

module issue_stage (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        instr_valid,
    input  wire logic [isa_pkg::ILEN-1:0]    instr,
    input  wire logic [`XLEN-1:0]            instr_pc,
    input  wire logic [`XLEN-1:0]            rs1_data,
    input  wire logic [`XLEN-1:0]            rs2_data,
    input  wire logic [`NUM_UNITS-1:0]       credit_return,
    input  wire logic                        wb_valid,
    input  wire logic [`REG_ADDR_W-1:0]      wb_rd,
    output logic                             instr_ready,
    output logic                             illegal_instruction,
    output logic                             issue_valid,
    output issue_pkg::unit_t                 issue_unit,
    output logic [isa_pkg::FN3_W-1:0]        issue_fn3,
    output logic [`XLEN-1:0]                 issue_in1,
    output logic [`XLEN-1:0]                 issue_in2,
    output logic [`REG_ADDR_W-1:0]           issue_rd,
    output logic [`XLEN-1:0]                 issue_pc
);
    import issue_pkg::*;

    logic                  is_legal;
    unit_t                 dec_unit;
    operand_sel_t          dec_operand_sel;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  writes_rd;
    logic                  hazard;
    logic [`NUM_UNITS-1:0] has_credit;
    logic                  legal_fire;

    //////////////////////////////////////////////////
    // Issue decision
    assign legal_fire  = is_legal && !hazard && has_credit[dec_unit];
    // Illegal encodings are consumed without issue
    assign instr_ready = illegal_instruction || legal_fire;

    instr_decoder decoder_i (
        .instr_valid         (instr_valid),
        .instr               (instr),
        .illegal_instruction (illegal_instruction),
        .is_legal            (is_legal),
        .unit                (dec_unit),
        .operand_sel         (dec_operand_sel),
        .uses_rs1            (uses_rs1),
        .uses_rs2            (uses_rs2),
        .writes_rd           (writes_rd)
    );

    reg_scoreboard scoreboard_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (instr[19:15]),
        .rs2_addr  (instr[24:20]),
        .rd_addr   (instr[11:7]),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd),
        .set_busy  (legal_fire),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .hazard    (hazard)
    );

    unit_credit_pool credit_pool_i (
        .clk           (clk),
        .rst           (rst),
        .take_valid    (legal_fire),
        .take_unit     (dec_unit),
        .credit_return (credit_return),
        .has_credit    (has_credit)
    );

    operand_issue_reg issue_reg_i (
        .clk         (clk),
        .rst         (rst),
        .fire        (legal_fire),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .unit        (dec_unit),
        .operand_sel (dec_operand_sel),
        .issue_valid (issue_valid),
        .issue_unit  (issue_unit),
        .issue_fn3   (issue_fn3),
        .issue_in1   (issue_in1),
        .issue_in2   (issue_in2),
        .issue_rd    (issue_rd),
        .issue_pc    (issue_pc)
    );

endmodule

`default_nettype wire

/* design/operand_issue_reg.sv */
// Operand formation and the registered issue packet presented to the execution units
`default_nettype none

`include "issue_config.svh"

module operand_issue_reg (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          fire,
    input  wire logic [isa_pkg::ILEN-1:0]      instr,
    input  wire logic [`XLEN-1:0]              instr_pc,
    input  wire logic [`XLEN-1:0]              rs1_data,
    input  wire logic [`XLEN-1:0]              rs2_data,
    input  wire issue_pkg::unit_t              unit,
    input  wire issue_pkg::operand_sel_t       operand_sel,
    output logic                               issue_valid,
    output issue_pkg::unit_t                   issue_unit,
    output logic [isa_pkg::FN3_W-1:0]          issue_fn3,
    output logic [`XLEN-1:0]                   issue_in1,
    output logic [`XLEN-1:0]                   issue_in2,
    output logic [`REG_ADDR_W-1:0]             issue_rd,
    output logic [`XLEN-1:0]                   issue_pc
);
    import issue_pkg::*;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [11:0]      ls_offset;
    logic [`XLEN-1:0] in1;
    logic [`XLEN-1:0] in2;

    //////////////////////////////////////////////////
    // Immediates
    assign imm_i = `XLEN'(signed'(instr[31:20]));
    assign imm_u = {instr[31:12], 12'b0};

    // Stores split the offset around the rd field (opcode bit 5 marks a store)
    assign ls_offset = instr[5] ? {instr[31:25], instr[11:7]} : instr[31:20];

    //////////////////////////////////////////////////
    // Operand select
    always_comb begin
        case (operand_sel)
            SEL_RS1_IMM: begin
                in1 = rs1_data;
                in2 = imm_i;
            end
            SEL_ZERO_UPPER: begin
                in1 = '0;
                in2 = imm_u;
            end
            SEL_PC_UPPER: begin
                in1 = instr_pc;
                in2 = imm_u;
            end
            SEL_ADDR_RS2: begin
                in1 = rs1_data + `XLEN'(signed'(ls_offset));
                in2 = rs2_data;
            end
            default: begin
                in1 = rs1_data;
                in2 = rs2_data;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Issue packet, valid for the cycle after fire
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue_unit <= unit;
            issue_fn3  <= instr[14:12];
            issue_in1  <= in1;
            issue_in2  <= in2;
            issue_rd   <= instr[11:7];
            issue_pc   <= instr_pc;
        end
    end

endmodule

`default_nettype wire

/* design/reg_scoreboard.sv */
// Register scoreboard: busy bits set at issue, cleared at writeback, with hazard detection
`default_nettype none

`include "issue_config.svh"

module reg_scoreboard (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [`REG_ADDR_W-1:0] rs1_addr,
    input  wire logic [`REG_ADDR_W-1:0] rs2_addr,
    input  wire logic [`REG_ADDR_W-1:0] rd_addr,
    input  wire logic                   uses_rs1,
    input  wire logic                   uses_rs2,
    input  wire logic                   writes_rd,
    input  wire logic                   set_busy,
    input  wire logic                   wb_valid,
    input  wire logic [`REG_ADDR_W-1:0] wb_rd,
    output logic                        hazard
);

    logic [`NUM_REGS-1:0] busy;

    //////////////////////////////////////////////////
    // Busy bits
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            // Issue set comes last so it wins over a same-cycle writeback
            if (set_busy && writes_rd) begin
                busy[rd_addr] <= 1'b1;
            end
        end
    end

    // No writeback bypass, registered bits only
    assign hazard = (uses_rs1 && busy[rs1_addr]) ||
                    (uses_rs2 && busy[rs2_addr]) ||
                    (writes_rd && busy[rd_addr]);

    //////////////////////////////////////////////////
    // Assertions
    x0_never_busy: assert property (@(posedge clk) disable iff (rst) !busy[0])
        else $error("register zero marked busy");

endmodule

`default_nettype wire

/* design/unit_credit_pool.sv */
// Per-unit credit counters tracking free input-buffer slots in each execution unit
`default_nettype none

`include "issue_config.svh"

module unit_credit_pool (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  take_valid,
    input  wire issue_pkg::unit_t      take_unit,
    input  wire logic [`NUM_UNITS-1:0] credit_return,
    output logic [`NUM_UNITS-1:0]      has_credit
);
    import issue_pkg::*;

    genvar i;

    generate
        for (i = 0; i < `NUM_UNITS; i++) begin : g_unit
            logic                 take;
            logic [`CREDIT_W-1:0] credits;

            assign take = take_valid && (take_unit == unit_t'(i));

            // Take and return in one cycle cancel out
            always_ff @(posedge clk) begin
                if (rst) begin
                    credits <= `CREDIT_W'(`UNIT_CREDITS);
                end else if (take && !credit_return[i]) begin
                    credits <= credits - 1'b1;
                end else if (!take && credit_return[i]) begin
                    credits <= credits + 1'b1;
                end
            end

            assign has_credit[i] = (credits != '0);

            take_from_empty: assert property (@(posedge clk) disable iff (rst)
                take |-> credits != '0)
                else $error("unit %0d issued with no credit", i);

            return_overflow: assert property (@(posedge clk) disable iff (rst)
                (credit_return[i] && !take) |-> credits < `CREDIT_W'(`UNIT_CREDITS))
                else $error("unit %0d returned more credits than it holds", i);
        end
    endgenerate

endmodule

`default_nettype wire

/* issue_stage.f */
+incdir+design
design/isa_pkg.sv
design/issue_pkg.sv
design/instr_decoder.sv
design/reg_scoreboard.sv
design/unit_credit_pool.sv
design/operand_issue_reg.sv
design/issue_stage.sv
test/tb_clock_gen.sv
test/issue_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build the issue stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f issue_stage.f \
    --top-module issue_stage_tb -o issue_stage_sim

out=$(./obj_dir/issue_stage_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TB PASSED"

/* test/issue_stage_tb.sv */
// Issue stage testbench driving a random instruction stream against a register and credit model
`default_nettype none

`include "issue_config.svh"

module issue_stage_tb;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int NUM_INSTRS    = 2000;
    localparam int CYCLE_LIMIT   = 40000;
    localparam int RESET_TIMEOUT = 20;
    localparam int SAMPLE_DELAY  = 10;
    localparam int HOLD_SPAN     = 60;

    // Instruction kinds with the legal ones first
    localparam int K_LUI = 0, K_AUIPC = 1, K_JAL = 2, K_JALR = 3, K_BRANCH = 4;
    localparam int K_LOAD = 5, K_STORE = 6, K_ARITH_IMM = 7, K_ARITH = 8, K_MUL = 9;
    localparam int K_DIV = 10, K_BAD_LOW = 11, K_BAD_OPC = 12;

    typedef struct packed {
        unit_t              exec_unit;
        logic [FN3_W-1:0]   fn3;
        logic [`XLEN-1:0]   in1;
        logic [`XLEN-1:0]   in2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]   pc;
    } issue_pkt_t;

    typedef struct packed {
        int                     due;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   writes;
    } ret_entry_t;

    logic clk, rst;
    logic instr_valid, instr_ready, illegal_instruction, issue_valid, wb_valid;
    logic [ILEN-1:0] instr;
    logic [`XLEN-1:0] instr_pc, rs1_data, rs2_data, issue_in1, issue_in2, issue_pc;
    logic [`NUM_UNITS-1:0] credit_return;
    logic [`REG_ADDR_W-1:0] wb_rd, issue_rd;
    logic [FN3_W-1:0] issue_fn3;
    unit_t issue_unit;

    // Model state
    logic [31:0] lfsr_state;
    logic busy [`NUM_REGS];
    int credits [`NUM_UNITS];
    int takes_in_hold [`NUM_UNITS];
    ret_entry_t ret_q [`NUM_UNITS][$];
    issue_pkt_t expected_q [$];

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) clock_gen_i (.clk(clk), .rst(rst));

    issue_stage dut_i (.*);

    //////////////////////////////////////////////////
    // Random numbers and instruction building

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic opcode_known(input logic [OPC_W-1:0] opc);
        case (opc)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH: return 1'b1;
            OP_LOAD, OP_STORE, OP_ARITH_IMM, OP_ARITH: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [ILEN-1:0] build_instr(input int kind);
        logic [6:0]       f7;
        logic [4:0]       rs2, rs1, rd;
        logic [FN3_W-1:0] fn3;
        logic [OPC_W-1:0] opc;
        logic [1:0]       low;
        // Registers limited to x0..x3 so hazards come often
        f7  = 7'(rand_bits(7));
        rs2 = 5'(rand_bits(2));
        rs1 = 5'(rand_bits(2));
        fn3 = 3'(rand_bits(3));
        rd  = 5'(rand_bits(2));
        low = 2'b11;
        opc = OP_ARITH;
        case (kind)
            K_LUI:       opc = OP_LUI;
            K_AUIPC:     opc = OP_AUIPC;
            K_JAL:       opc = OP_JAL;
            K_JALR:      opc = OP_JALR;
            K_BRANCH:    opc = OP_BRANCH;
            K_LOAD:      opc = OP_LOAD;
            K_STORE:     opc = OP_STORE;
            K_ARITH_IMM: opc = OP_ARITH_IMM;
            K_ARITH:     f7[0] = 1'b0;
            K_MUL: begin
                f7[0]  = 1'b1;
                fn3[2] = 1'b0;
            end
            K_DIV: begin
                f7[0]  = 1'b1;
                fn3[2] = 1'b1;
            end
            K_BAD_LOW: begin
                low = 2'(rand_bits(2));
                if (low == 2'b11) low = 2'b01;
            end
            default: begin
                opc = 5'(rand_bits(5));
                while (opcode_known(opc)) opc = opc + 5'd1;
            end
        endcase
        return {f7, rs2, rs1, fn3, rd, opc, low};
    endfunction

    //////////////////////////////////////////////////
    // Expected behavior per kind

    function automatic unit_t kind_unit(input int kind);
        case (kind)
            K_JAL, K_JALR, K_BRANCH: return UNIT_BRANCH;
            K_LOAD, K_STORE:         return UNIT_LSU;
            K_MUL:                   return UNIT_MUL;
            default:                 return UNIT_ALU;
        endcase
    endfunction

    function automatic issue_pkt_t expected_packet(input int kind, input logic [ILEN-1:0] ins,
            input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        issue_pkt_t       p;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] imm_u;
        imm_i = {{(`XLEN-12){ins[31]}}, ins[31:20]};
        imm_s = {{(`XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
        imm_u = {ins[31:12], 12'h000};
        p.exec_unit = kind_unit(kind);
        p.fn3 = ins[14:12];
        p.rd  = ins[11:7];
        p.pc  = pc;
        p.in1 = a;
        p.in2 = b;
        case (kind)
            K_LUI: begin
                p.in1 = '0;
                p.in2 = imm_u;
            end
            K_AUIPC: begin
                p.in1 = pc;
                p.in2 = imm_u;
            end
            K_JALR, K_ARITH_IMM: p.in2 = imm_i;
            K_LOAD:  p.in1 = a + imm_i;
            K_STORE: p.in1 = a + imm_s;
            default: ;
        endcase
        return p;
    endfunction

    //////////////////////////////////////////////////
    // Failure reporting and compares

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_unit(input string name, input unit_t got, input unit_t exp);
        if (got !== exp)
            stop_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Stimulus and model

    initial begin
        int cycle, wait_cycles, n_sent, n_done, kind, sel, delay;
        logic have_instr, holding, was_holding, issue_due, finished;
        logic legal, hazard, writes, exp_ready, wb_now;
        logic [`REG_ADDR_W-1:0] rs1, rs2, rd, wb_reg;
        logic [`NUM_UNITS-1:0] ret_bits;
        issue_pkt_t pkt;
        ret_entry_t ent;

        instr_valid = 1'b0;
        instr = '0;
        instr_pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        credit_return = '0;
        wb_valid = 1'b0;
        wb_rd = '0;
        lfsr_state = 32'h5890;
        for (int r = 0; r < `NUM_REGS; r++) busy[r] = 1'b0;
        for (int u = 0; u < `NUM_UNITS; u++) credits[u] = `UNIT_CREDITS;
        cycle = 0;
        n_sent = 0;
        n_done = 0;
        kind = K_ARITH_IMM;
        have_instr = 1'b0;
        was_holding = 1'b0;
        issue_due = 1'b0;
        finished = 1'b0;

        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) stop_run("reset was never released");
        end while (rst !== 1'b0);

        while (!finished) begin
            @(negedge clk);
            cycle++;
            if (cycle > CYCLE_LIMIT) stop_run("timed out before all instructions issued");

            // Returns are withheld for one span out of every four
            holding = ((cycle / HOLD_SPAN) % 4) == 3;
            if (holding && !was_holding) begin
                for (int u = 0; u < `NUM_UNITS; u++) takes_in_hold[u] = 0;
            end
            was_holding = holding;

            // Units with rd results take turns on the single writeback port
            ret_bits = '0;
            wb_now = 1'b0;
            wb_reg = '0;
            for (int u = 0; u < `NUM_UNITS; u++) begin
                if (!holding && ret_q[u].size() > 0 && ret_q[u][0].due <= cycle &&
                    !(ret_q[u][0].writes && wb_now)) begin
                    ent = ret_q[u].pop_front();
                    ret_bits[u] = 1'b1;
                    if (ent.writes) begin
                        wb_now = 1'b1;
                        wb_reg = ent.rd;
                    end
                end
            end
            credit_return = ret_bits;
            wb_valid = wb_now;
            wb_rd = wb_reg;

            // New instruction only once the previous one is consumed
            if (!have_instr && n_sent < NUM_INSTRS && rand_bits(3) != 0) begin
                kind = int'(rand_bits(4));
                if (kind > K_BAD_OPC) kind = kind - 8;
                if (n_sent == 0) kind = K_ARITH_IMM;
                instr = build_instr(kind);
                instr_pc = rand_bits(30) << 2;
                rs1_data = rand_bits(32);
                rs2_data = rand_bits(32);
                have_instr = 1'b1;
                n_sent++;
            end
            instr_valid = have_instr;

            #SAMPLE_DELAY;

            // Registered packet from the previous edge
            check_bit("issue_valid", issue_valid, issue_due);
            if (issue_due) begin
                pkt = expected_q.pop_front();
                check_unit("issue_unit", issue_unit, pkt.exec_unit);
                check_word("issue_fn3", `XLEN'(issue_fn3), `XLEN'(pkt.fn3));
                check_word("issue_in1", issue_in1, pkt.in1);
                check_word("issue_in2", issue_in2, pkt.in2);
                check_word("issue_rd", `XLEN'(issue_rd), `XLEN'(pkt.rd));
                check_word("issue_pc", issue_pc, pkt.pc);
            end
            issue_due = 1'b0;

            // Ready and illegal prediction
            legal = kind <= K_MUL;
            sel = int'(kind_unit(kind));
            rs1 = instr[19:15];
            rs2 = instr[24:20];
            rd = instr[11:7];
            writes = !(kind inside {K_BRANCH, K_STORE}) && rd != '0;
            hazard = (!(kind inside {K_LUI, K_AUIPC, K_JAL}) && busy[rs1]) ||
                     ((kind inside {K_BRANCH, K_STORE, K_ARITH, K_MUL}) && busy[rs2]) ||
                     (writes && busy[rd]);
            exp_ready = instr_valid && (!legal || (!hazard && credits[sel] > 0));

            // Acceptances seen at the DUT while returns are withheld
            if (holding && legal && instr_valid && instr_ready === 1'b1) begin
                takes_in_hold[sel]++;
                if (takes_in_hold[sel] > `UNIT_CREDITS)
                    stop_run("a unit accepted more instructions than its credits allow");
            end

            check_bit("illegal_instruction", illegal_instruction, instr_valid && !legal);
            if (instr_valid) check_bit("instr_ready", instr_ready, exp_ready);

            // Model update for the coming edge where issue set wins over writeback
            if (wb_valid) busy[wb_rd] = 1'b0;
            for (int u = 0; u < `NUM_UNITS; u++) begin
                if (ret_bits[u]) credits[u]++;
            end
            if (exp_ready) begin
                have_instr = 1'b0;
                n_done++;
                if (legal) begin
                    credits[sel]--;
                    if (writes) busy[rd] = 1'b1;
                    expected_q.push_back(expected_packet(kind, instr, instr_pc,
                                                         rs1_data, rs2_data));
                    issue_due = 1'b1;
                    delay = int'(rand_bits(3));
                    ent.due = cycle + 1 + delay;
                    ent.rd = rd;
                    ent.writes = writes;
                    ret_q[sel].push_back(ent);
                end
            end

            finished = (n_done == NUM_INSTRS) && (expected_q.size() == 0);
            for (int u = 0; u < `NUM_UNITS; u++) begin
                if (ret_q[u].size() > 0) finished = 1'b0;
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// Testbench clock and reset source: free-running clock and a synchronous reset pulse
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a rising edge, so the DUT sees exactly RESET_CYCLES edges in reset
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
